// ==== source/tlp_pkg.sv ====
`default_nettype none

package tlp_pkg;

   // widths
   localparam int data_width     = 64;
   localparam int keep_width     = data_width / 8;
   localparam int reg_addr_width = 13;
   localparam int addr_width     = 32;
   localparam int id_width       = 16;
   localparam int rid_tag_width  = 24;
   localparam int count_width    = 16;
   localparam int fmt_width      = 7;

   // format/type codes, 3-DW headers only
   localparam logic [fmt_width-1:0] fmt_mwr32 = 7'h40;
   localparam logic [fmt_width-1:0] fmt_mrd32 = 7'h00;
   localparam logic [fmt_width-1:0] fmt_cpld  = 7'h4a;

   localparam logic [9:0]            payload_dwords = 10'd2;
   localparam logic [11:0]           cpl_byte_count = 12'd8;
   localparam logic [7:0]            byte_enables   = 8'hff;
   localparam logic [keep_width-1:0] keep_full      = 8'hff;
   localparam logic [keep_width-1:0] keep_low       = 8'h0f;

   // field positions in beat 0 and beat 1
   localparam int fmt_lsb     = 24;
   localparam int rid_tag_lsb = 40;
   localparam int index_lsb   = 3;

   // register map
   localparam logic [reg_addr_width-1:0] reg_scratch        = 13'd0;
   localparam logic [reg_addr_width-1:0] reg_cpl_count      = 13'd1;
   localparam logic [reg_addr_width-1:0] reg_write_count    = 13'd2;
   localparam logic [reg_addr_width-1:0] reg_read_count     = 13'd3;
   localparam logic [reg_addr_width-1:0] reg_write_doorbell = 13'd100;
   localparam logic [reg_addr_width-1:0] reg_read_doorbell  = 13'd101;
   localparam logic [reg_addr_width-1:0] reg_irq_doorbell   = 13'd102;

   // reset and default values
   localparam logic [31:0]           default_read_tag = 32'hdeadbeef;
   localparam logic [data_width-1:0] write_data_start = 64'h100;
   localparam logic [3:0]            led_reset        = 4'h5;

endpackage

`default_nettype wire

// ==== source/pcie_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module pcie_rx
(
   input  wire                                 clock,
   input  wire                                 rst,
   input  wire  [tlp_pkg::data_width-1:0]      rx_tdata,
   input  wire                                 rx_tvalid,
   input  wire                                 rx_tlast,
   output logic                                write_valid,
   output logic                                read_valid,
   output logic                                completion_valid,
   output logic [tlp_pkg::reg_addr_width-1:0]  rx_address,
   output logic [tlp_pkg::data_width-1:0]      rx_data,
   output logic [tlp_pkg::rid_tag_width-1:0]   rx_rid_tag
);
   import tlp_pkg::*;

   logic [1:0]           beat_count;
   logic [fmt_width-1:0] fmt_type;
   logic                 last_beat;

   // a packet needs at least two beats
   assign last_beat = rx_tvalid && rx_tlast && (beat_count != 2'd0);

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         beat_count       <= 2'd0;
         write_valid      <= 1'b0;
         read_valid       <= 1'b0;
         completion_valid <= 1'b0;
      end
      else
      begin
         // unknown types fall through with no pulse
         write_valid      <= last_beat && (fmt_type == fmt_mwr32);
         read_valid       <= last_beat && (fmt_type == fmt_mrd32);
         completion_valid <= last_beat && (fmt_type == fmt_cpld);
         if (rx_tvalid)
         begin
            if (rx_tlast)
               beat_count <= 2'd0;
            else if (beat_count != 2'd3)
               beat_count <= beat_count + 2'd1;
         end
      end
   end

   // header fields and payload
   always_ff @(posedge clock)
   begin
      if (rx_tvalid)
      begin
         if (beat_count == 2'd0)
         begin
            fmt_type   <= rx_tdata[fmt_lsb +: fmt_width];
            rx_rid_tag <= rx_tdata[rid_tag_lsb +: rid_tag_width];
         end
         else if (beat_count == 2'd1)
         begin
            // DW2 of a completion is not an address
            if (fmt_type == fmt_cpld)
               rx_address <= '0;
            else
               rx_address <= rx_tdata[index_lsb +: reg_addr_width];
            rx_data[31:0] <= rx_tdata[63:32];
         end
         else if (beat_count == 2'd2)
         begin
            rx_data[63:32] <= rx_tdata[31:0];
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/pcie_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module pcie_regs
(
   input  wire                                 clock,
   input  wire                                 rst,
   input  wire                                 write_valid,
   input  wire                                 read_valid,
   input  wire                                 completion_valid,
   input  wire  [tlp_pkg::reg_addr_width-1:0]  rx_address,
   input  wire  [tlp_pkg::data_width-1:0]      rx_data,
   input  wire  [tlp_pkg::rid_tag_width-1:0]   rx_rid_tag,
   output logic                                cpl_valid,
   output logic [tlp_pkg::rid_tag_width-1:0]   cpl_rid_tag,
   output logic [3:0]                          cpl_lower_addr,
   output logic [tlp_pkg::data_width-1:0]      cpl_data,
   input  wire                                 cpl_ready,
   output logic                                wr_req_valid,
   output logic [tlp_pkg::addr_width-1:0]      wr_req_address,
   output logic [tlp_pkg::data_width-1:0]      wr_req_data,
   input  wire                                 wr_req_ready,
   output logic                                rd_req_valid,
   output logic [tlp_pkg::addr_width-1:0]      rd_req_address,
   input  wire                                 rd_req_ready,
   output logic                                irq,
   input  wire                                 irq_ack,
   input  wire                                 to_turnoff,
   output logic                                turnoff_ok,
   output logic [3:0]                          led
);
   import tlp_pkg::*;

   logic [data_width-1:0]     scratch;
   logic [count_width-1:0]    cpl_count;
   logic [count_width-1:0]    write_count;
   logic [count_width-1:0]    read_count;
   logic [count_width-1:0]    read_count_next;
   logic [data_width-1:0]     read_data;
   logic [3:0]                read_index;
   logic [rid_tag_width-1:0]  read_rid_tag;
   logic                      read_done;
   logic                      wr_doorbell;
   logic                      rd_doorbell;
   logic                      irq_doorbell;

   assign wr_doorbell     = write_valid && (rx_address == reg_write_doorbell);
   assign rd_doorbell     = write_valid && (rx_address == reg_read_doorbell);
   assign irq_doorbell    = write_valid && (rx_address == reg_irq_doorbell);
   // the read being answered counts itself
   assign read_count_next = read_count + 1'b1;

   always_ff @(posedge clock)
   begin
      if ((write_valid && (rx_address == reg_scratch)) || completion_valid)
         scratch <= rx_data;
      if (read_valid)
      begin
         read_index   <= rx_address[3:0];
         read_rid_tag <= rx_rid_tag;
         case (rx_address)
            reg_scratch:     read_data <= scratch;
            reg_cpl_count:   read_data <= {{(data_width-count_width){1'b0}}, cpl_count};
            reg_write_count: read_data <= {{(data_width-count_width){1'b0}}, write_count};
            reg_read_count:  read_data <= {{(data_width-count_width){1'b0}}, read_count_next};
            default:
               read_data <= {{(data_width-32-reg_addr_width){1'b0}}, rx_address,
                             default_read_tag};
         endcase
      end
      if (read_done)
      begin
         cpl_rid_tag    <= read_rid_tag;
         cpl_lower_addr <= read_index;
         cpl_data       <= read_data;
      end
      if (wr_doorbell)
         wr_req_address <= rx_data[addr_width-1:0];
      if (rd_doorbell)
         rd_req_address <= rx_data[addr_width-1:0];
   end

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         cpl_count    <= '0;
         write_count  <= '0;
         read_count   <= '0;
         led          <= led_reset;
         irq          <= 1'b0;
         turnoff_ok   <= 1'b0;
         read_done    <= 1'b0;
         cpl_valid    <= 1'b0;
         wr_req_valid <= 1'b0;
         wr_req_data  <= write_data_start;
         rd_req_valid <= 1'b0;
      end
      else
      begin
         if (completion_valid)
            cpl_count <= cpl_count + 1'b1;
         if (write_valid)
         begin
            write_count <= write_count + 1'b1;
            led         <= rx_data[3:0];
         end
         if (read_valid)
            read_count <= read_count_next;
         if (irq_doorbell)
            irq <= 1'b1;
         else if (irq_ack)
            irq <= 1'b0;
         // hold off while any read is still on its way out
         turnoff_ok <= to_turnoff && !(read_valid || read_done || cpl_valid);
         read_done  <= read_valid;
         // a newer read replaces a completion not yet taken
         if (read_done)
            cpl_valid <= 1'b1;
         else if (cpl_ready)
            cpl_valid <= 1'b0;
         if (wr_doorbell)
            wr_req_valid <= 1'b1;
         else if (wr_req_ready)
            wr_req_valid <= 1'b0;
         if (wr_req_valid && wr_req_ready)
            wr_req_data <= wr_req_data + 1'b1;
         if (rd_doorbell)
            rd_req_valid <= 1'b1;
         else if (rd_req_ready)
            rd_req_valid <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== source/pcie_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module pcie_tx
(
   input  wire                                 clock,
   input  wire                                 rst,
   input  wire  [tlp_pkg::id_width-1:0]        pcie_id,
   input  wire                                 cpl_valid,
   input  wire  [tlp_pkg::rid_tag_width-1:0]   cpl_rid_tag,
   input  wire  [3:0]                          cpl_lower_addr,
   input  wire  [tlp_pkg::data_width-1:0]      cpl_data,
   output logic                                cpl_ready,
   input  wire                                 wr_req_valid,
   input  wire  [tlp_pkg::addr_width-1:0]      wr_req_address,
   input  wire  [tlp_pkg::data_width-1:0]      wr_req_data,
   output logic                                wr_req_ready,
   input  wire                                 rd_req_valid,
   input  wire  [tlp_pkg::addr_width-1:0]      rd_req_address,
   output logic                                rd_req_ready,
   output logic [tlp_pkg::data_width-1:0]      tx_tdata,
   output logic [tlp_pkg::keep_width-1:0]      tx_tkeep,
   output logic                                tx_tlast,
   output logic                                tx_tvalid,
   input  wire                                 tx_tready
);
   import tlp_pkg::*;

   typedef enum logic [1:0] {st_idle, st_beat0, st_beat1, st_beat2} state_t;

   state_t                state;
   logic                  start;
   logic                  advance;
   logic                  two_beat;
   logic                  two_beat_next;
   logic [31:0]           dw0;
   logic [31:0]           dw1;
   logic [31:0]           dw2;
   logic [data_width-1:0] payload;
   logic [data_width-1:0] beat1_data;
   logic [31:0]           beat2_data;

   // priority pick and header build
   always_comb
   begin
      cpl_ready     = 1'b0;
      wr_req_ready  = 1'b0;
      rd_req_ready  = 1'b0;
      // memory read header unless something else wins
      dw0           = {1'b0, fmt_mrd32, 14'b0, payload_dwords};
      dw1           = {pcie_id, 8'h00, byte_enables};
      dw2           = {rd_req_address[addr_width-1:2], 2'b00};
      payload       = '0;
      two_beat_next = 1'b1;
      if (state == st_idle)
      begin
         if (cpl_valid)
         begin
            cpl_ready     = 1'b1;
            dw0           = {1'b0, fmt_cpld, 14'b0, payload_dwords};
            dw1           = {pcie_id, 4'b0, cpl_byte_count};
            dw2           = {cpl_rid_tag, 1'b0, cpl_lower_addr, 3'b000};
            payload       = cpl_data;
            two_beat_next = 1'b0;
         end
         else if (wr_req_valid)
         begin
            wr_req_ready  = 1'b1;
            dw0           = {1'b0, fmt_mwr32, 14'b0, payload_dwords};
            dw2           = {wr_req_address[addr_width-1:2], 2'b00};
            payload       = wr_req_data;
            two_beat_next = 1'b0;
         end
         else if (rd_req_valid)
         begin
            rd_req_ready = 1'b1;
         end
      end
   end

   assign start   = cpl_ready || wr_req_ready || rd_req_ready;
   assign advance = tx_tvalid && tx_tready;

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         state     <= st_idle;
         tx_tvalid <= 1'b0;
      end
      else
      begin
         case (state)
            st_idle:
               if (start)
               begin
                  state     <= st_beat0;
                  tx_tvalid <= 1'b1;
               end
            st_beat0:
               if (tx_tready)
                  state <= st_beat1;
            st_beat1:
               if (tx_tready)
               begin
                  if (two_beat)
                  begin
                     state     <= st_idle;
                     tx_tvalid <= 1'b0;
                  end
                  else
                     state <= st_beat2;
               end
            default:
               if (tx_tready)
               begin
                  state     <= st_idle;
                  tx_tvalid <= 1'b0;
               end
         endcase
      end
   end

   // beat registers hold while stalled
   always_ff @(posedge clock)
   begin
      if (start)
      begin
         tx_tdata   <= {dw1, dw0};
         tx_tkeep   <= keep_full;
         tx_tlast   <= 1'b0;
         beat1_data <= {payload[31:0], dw2};
         beat2_data <= payload[63:32];
         two_beat   <= two_beat_next;
      end
      else if (advance)
      begin
         if (state == st_beat0)
         begin
            tx_tdata <= beat1_data;
            tx_tkeep <= two_beat ? keep_low : keep_full;
            tx_tlast <= two_beat;
         end
         else if (state == st_beat1)
         begin
            tx_tdata <= {32'h0, beat2_data};
            tx_tkeep <= keep_low;
            tx_tlast <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/pcie_endpoint.sv ====
`timescale 1ns/100ps
`default_nettype none

module pcie_endpoint
(
   input  wire                                 clock,
   input  wire                                 rst,
   input  wire  [tlp_pkg::data_width-1:0]      rx_tdata,
   input  wire                                 rx_tvalid,
   input  wire                                 rx_tlast,
   output logic [tlp_pkg::data_width-1:0]      tx_tdata,
   output logic [tlp_pkg::keep_width-1:0]      tx_tkeep,
   output logic                                tx_tlast,
   output logic                                tx_tvalid,
   input  wire                                 tx_tready,
   input  wire  [tlp_pkg::id_width-1:0]        pcie_id,
   output logic                                irq,
   input  wire                                 irq_ack,
   input  wire                                 to_turnoff,
   output logic                                turnoff_ok,
   output logic [3:0]                          led
);
   import tlp_pkg::*;

   logic                      write_valid;
   logic                      read_valid;
   logic                      completion_valid;
   logic [reg_addr_width-1:0] rx_address;
   logic [data_width-1:0]     rx_data;
   logic [rid_tag_width-1:0]  rx_rid_tag;

   logic                      cpl_valid;
   logic [rid_tag_width-1:0]  cpl_rid_tag;
   logic [3:0]                cpl_lower_addr;
   logic [data_width-1:0]     cpl_data;
   logic                      cpl_ready;
   logic                      wr_req_valid;
   logic [addr_width-1:0]     wr_req_address;
   logic [data_width-1:0]     wr_req_data;
   logic                      wr_req_ready;
   logic                      rd_req_valid;
   logic [addr_width-1:0]     rd_req_address;
   logic                      rd_req_ready;

   pcie_rx u_rx
   (
      .clock(clock), .rst(rst),
      .rx_tdata(rx_tdata), .rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast),
      .write_valid(write_valid), .read_valid(read_valid),
      .completion_valid(completion_valid),
      .rx_address(rx_address), .rx_data(rx_data), .rx_rid_tag(rx_rid_tag)
   );

   pcie_regs u_regs
   (
      .clock(clock), .rst(rst),
      .write_valid(write_valid), .read_valid(read_valid),
      .completion_valid(completion_valid),
      .rx_address(rx_address), .rx_data(rx_data), .rx_rid_tag(rx_rid_tag),
      .cpl_valid(cpl_valid), .cpl_rid_tag(cpl_rid_tag),
      .cpl_lower_addr(cpl_lower_addr), .cpl_data(cpl_data), .cpl_ready(cpl_ready),
      .wr_req_valid(wr_req_valid), .wr_req_address(wr_req_address),
      .wr_req_data(wr_req_data), .wr_req_ready(wr_req_ready),
      .rd_req_valid(rd_req_valid), .rd_req_address(rd_req_address),
      .rd_req_ready(rd_req_ready),
      .irq(irq), .irq_ack(irq_ack),
      .to_turnoff(to_turnoff), .turnoff_ok(turnoff_ok), .led(led)
   );

   pcie_tx u_tx
   (
      .clock(clock), .rst(rst), .pcie_id(pcie_id),
      .cpl_valid(cpl_valid), .cpl_rid_tag(cpl_rid_tag),
      .cpl_lower_addr(cpl_lower_addr), .cpl_data(cpl_data), .cpl_ready(cpl_ready),
      .wr_req_valid(wr_req_valid), .wr_req_address(wr_req_address),
      .wr_req_data(wr_req_data), .wr_req_ready(wr_req_ready),
      .rd_req_valid(rd_req_valid), .rd_req_address(rd_req_address),
      .rd_req_ready(rd_req_ready),
      .tx_tdata(tx_tdata), .tx_tkeep(tx_tkeep), .tx_tlast(tx_tlast),
      .tx_tvalid(tx_tvalid), .tx_tready(tx_tready)
   );

endmodule

`default_nettype wire

// ==== bench/tlp_vectors.svh ====
`ifndef TLP_VECTORS_SVH
`define TLP_VECTORS_SVH

typedef enum logic [2:0]
{
   k_write, k_read, k_cpl_in, k_irq_ack, k_turnoff, k_hold, k_release
} kind_t;

typedef struct packed
{
   kind_t       kind;
   logic [12:0] index;
   logic [63:0] data;
   logic [23:0] rid_tag;
} entry_t;

localparam int num_entries = 25;

// kind, register index, data, requester id and tag
localparam entry_t vectors [num_entries] = '{
   '{k_write,   reg_scratch,        64'h0123_4567_89ab_cdef, 24'h000000},
   '{k_read,    reg_scratch,        64'h0,                   24'h12345a},
   '{k_cpl_in,  13'd0,              64'hfeed_face_0000_1111, 24'h000000},
   '{k_read,    reg_scratch,        64'h0,                   24'h0abc01},
   // counters include the read that asks
   '{k_read,    reg_cpl_count,      64'h0,                   24'h0abc02},
   '{k_read,    reg_write_count,    64'h0,                   24'h0abc03},
   '{k_read,    reg_read_count,     64'h0,                   24'h0abc04},
   '{k_read,    13'h1a5,            64'h0,                   24'h777705},
   // doorbells, low address bits are dropped
   '{k_write,   reg_write_doorbell, 64'h0000_0000_4000_1004, 24'h000000},
   '{k_write,   reg_read_doorbell,  64'h0000_0000_8000_2008, 24'h000000},
   '{k_write,   reg_write_doorbell, 64'h0000_0000_4000_3002, 24'h000000},
   '{k_write,   reg_irq_doorbell,   64'h0000_0000_0000_0006, 24'h000000},
   '{k_write,   reg_scratch,        64'h0000_0000_0000_0a33, 24'h000000},
   '{k_irq_ack, 13'd0,              64'h0,                   24'h000000},
   '{k_turnoff, 13'd0,              64'h1,                   24'h000000},
   '{k_turnoff, 13'd0,              64'h0,                   24'h000000},
   // read request stalls in tx, then completion and write request both wait
   '{k_hold,    13'd0,              64'h0,                   24'h000000},
   '{k_write,   reg_read_doorbell,  64'h0000_0000_9000_0010, 24'h000000},
   '{k_read,    reg_scratch,        64'h0,                   24'h555507},
   '{k_write,   reg_write_doorbell, 64'h0000_0000_4000_4000, 24'h000000},
   '{k_turnoff, 13'd0,              64'h1,                   24'h000000},
   '{k_release, 13'd0,              64'h0,                   24'h000000},
   '{k_turnoff, 13'd0,              64'h1,                   24'h000000},
   '{k_read,    reg_write_count,    64'h0,                   24'h0abc08},
   '{k_read,    reg_read_count,     64'h0,                   24'h0abc09}
};

`endif

// ==== bench/pcie_endpoint_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module pcie_endpoint_tb;
   import tlp_pkg::*;

   logic        clock = 1'b0;
   logic        rst;
   logic [63:0] rx_tdata;
   logic        rx_tvalid;
   logic        rx_tlast;
   logic [63:0] tx_tdata;
   logic [7:0]  tx_tkeep;
   logic        tx_tlast;
   logic        tx_tvalid;
   logic        tx_tready = 1'b0;
   logic [15:0] pcie_id;
   logic        irq;
   logic        irq_ack;
   logic        to_turnoff;
   logic        turnoff_ok;
   logic [3:0]  led;

   `include "tlp_vectors.svh"

   localparam int cycle_limit = 8 + 80 * num_entries;

   // beats as {last, keep, data}
   logic [72:0] expect_q [$];
   logic [72:0] tx_beat;
   logic [72:0] stalled_beat;
   logic        stalled;
   logic        hold;
   logic        ready_next;
   int          cycle_count = 0;

   logic [63:0] scratch_model;
   logic [63:0] wr_payload;
   logic [15:0] cpls_seen;
   logic [15:0] writes_seen;
   logic [15:0] reads_seen;
   logic        irq_model;
   logic [3:0]  led_model;
   logic        cpl_held;

   pcie_endpoint u_dut
   (
      .clock(clock), .rst(rst),
      .rx_tdata(rx_tdata), .rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast),
      .tx_tdata(tx_tdata), .tx_tkeep(tx_tkeep), .tx_tlast(tx_tlast),
      .tx_tvalid(tx_tvalid), .tx_tready(tx_tready),
      .pcie_id(pcie_id), .irq(irq), .irq_ack(irq_ack),
      .to_turnoff(to_turnoff), .turnoff_ok(turnoff_ok), .led(led)
   );

   assign tx_beat = {tx_tlast, tx_tkeep, tx_tdata};

   always #20 clock = ~clock;

   task automatic abort_run();
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic report_failure(input string what);
      $display("%s", what);
      abort_run();
   endtask

   task automatic report_mismatch(input string name, input logic [72:0] got,
                                  input logic [72:0] want);
      $display("mismatch %s got 0x%0h expected 0x%0h", name, got, want);
      abort_run();
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clock);
      #2;
   endtask

   task automatic drive_beat(input logic [63:0] data, input logic last);
      rx_tdata  = data;
      rx_tvalid = 1'b1;
      rx_tlast  = last;
      wait_cycles(1);
   endtask

   task automatic send_packet(input logic [6:0] fmt, input logic [12:0] index,
                              input logic [63:0] data, input logic [23:0] rid_tag);
      logic [31:0] dw2;
      dw2 = {16'h0, index, 3'b000};
      drive_beat({rid_tag, 8'hff, 1'b0, fmt, 14'h0, payload_dwords}, 1'b0);
      if (fmt == fmt_mrd32)
         drive_beat({32'h0, dw2}, 1'b1);
      else
      begin
         drive_beat({data[31:0], dw2}, 1'b0);
         drive_beat({32'h0, data[63:32]}, 1'b1);
      end
      rx_tvalid = 1'b0;
      rx_tlast  = 1'b0;
   endtask

   task automatic push_packet(input logic [6:0] fmt, input logic [31:0] dw1,
                              input logic [31:0] dw2, input logic [63:0] payload);
      logic [31:0] dw0;
      dw0 = {1'b0, fmt, 14'h0, payload_dwords};
      expect_q.push_back({1'b0, 8'hff, dw1, dw0});
      if (fmt == fmt_mrd32)
         expect_q.push_back({1'b1, 8'h0f, 32'h0, dw2});
      else
      begin
         expect_q.push_back({1'b0, 8'hff, payload[31:0], dw2});
         expect_q.push_back({1'b1, 8'h0f, 32'h0, payload[63:32]});
      end
   endtask

   task automatic run_entry(input entry_t e);
      logic [63:0] value;
      value = '0;
      case (e.kind)
         k_write:
         begin
            writes_seen = writes_seen + 16'd1;
            led_model   = e.data[3:0];
            if (e.index == reg_scratch)
               scratch_model = e.data;
            else if (e.index == reg_write_doorbell)
            begin
               push_packet(fmt_mwr32, {pcie_id, 16'h00ff}, {e.data[31:2], 2'b00},
                           wr_payload);
               wr_payload = wr_payload + 64'd1;
            end
            else if (e.index == reg_read_doorbell)
               push_packet(fmt_mrd32, {pcie_id, 16'h00ff}, {e.data[31:2], 2'b00}, 64'h0);
            else if (e.index == reg_irq_doorbell)
               irq_model = 1'b1;
            send_packet(fmt_mwr32, e.index, e.data, e.rid_tag);
         end
         k_read:
         begin
            reads_seen = reads_seen + 16'd1;
            if (hold)
               cpl_held = 1'b1;
            if (e.index == reg_scratch)
               value = scratch_model;
            else if (e.index == reg_cpl_count)
               value = {48'h0, cpls_seen};
            else if (e.index == reg_write_count)
               value = {48'h0, writes_seen};
            else if (e.index == reg_read_count)
               value = {48'h0, reads_seen};
            else
               value = {19'h0, e.index, default_read_tag};
            // byte count is two dwords
            push_packet(fmt_cpld, {pcie_id, 4'h0, 12'd8},
                        {e.rid_tag, 1'b0, e.index[3:0], 3'b000}, value);
            send_packet(fmt_mrd32, e.index, 64'h0, e.rid_tag);
         end
         k_cpl_in:
         begin
            cpls_seen     = cpls_seen + 16'd1;
            scratch_model = e.data;
            send_packet(fmt_cpld, 13'd0, e.data, e.rid_tag);
         end
         k_irq_ack:
         begin
            irq_ack = 1'b1;
            wait_cycles(1);
            irq_ack   = 1'b0;
            irq_model = 1'b0;
         end
         k_turnoff:
         begin
            to_turnoff = e.data[0];
            wait_cycles(3);
            assert (turnoff_ok == (e.data[0] && !cpl_held))
            else report_mismatch("turnoff_ok", turnoff_ok, e.data[0] && !cpl_held);
         end
         k_hold:
            hold = 1'b1;
         default:
            hold = 1'b0;
      endcase
      wait_cycles(3);
      while (!hold && expect_q.size() != 0)
         wait_cycles(1);
      if (!hold)
         cpl_held = 1'b0;
      assert (irq == irq_model) else report_mismatch("irq", irq, irq_model);
      assert (led == led_model) else report_mismatch("led", led, led_model);
   endtask

   // tx_tready about 70% high, forced low while held
   always @(posedge clock)
   begin
      ready_next = !hold && (($urandom % 100) < 70);
      #2;
      tx_tready = ready_next;
   end

   // transmit monitor
   always @(posedge clock)
   begin
      if (!rst && stalled)
      begin
         assert (tx_tvalid) else report_failure("tx_tvalid dropped during a stall");
         assert (tx_beat == stalled_beat)
         else report_mismatch("tx_beat while stalled", tx_beat, stalled_beat);
      end
      if (!rst && tx_tvalid && tx_tready)
      begin
         assert (expect_q.size() != 0)
         else report_failure("transmit beat arrived with no packet expected");
         assert (tx_beat == expect_q[0])
         else report_mismatch("tx_beat", tx_beat, expect_q[0]);
         void'(expect_q.pop_front());
      end
      stalled      <= !rst && tx_tvalid && !tx_tready;
      stalled_beat <= tx_beat;
   end

   always @(posedge clock)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit)
         report_failure("timeout, transmit packets did not complete in time");
   end

   initial
   begin
      void'($urandom(61));
      rst           = 1'b1;
      rx_tdata      = '0;
      rx_tvalid     = 1'b0;
      rx_tlast      = 1'b0;
      irq_ack       = 1'b0;
      to_turnoff    = 1'b0;
      pcie_id       = 16'h0a18;
      hold          = 1'b0;
      stalled       = 1'b0;
      scratch_model = '0;
      wr_payload    = write_data_start;
      cpls_seen     = '0;
      writes_seen   = '0;
      reads_seen    = '0;
      irq_model     = 1'b0;
      led_model     = led_reset;
      cpl_held      = 1'b0;
      repeat (8) @(posedge clock);
      #2;
      rst = 1'b0;
      assert (!tx_tvalid) else report_failure("tx_tvalid high after reset");
      assert (!irq) else report_failure("irq high after reset");
      assert (!turnoff_ok) else report_failure("turnoff_ok high after reset");
      for (int i = 0; i < num_entries; i++)
         run_entry(vectors[i]);
      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+bench
source/tlp_pkg.sv
source/pcie_rx.sv
source/pcie_regs.sv
source/pcie_tx.sv
source/pcie_endpoint.sv
bench/pcie_endpoint_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# compile the endpoint testbench with verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module pcie_endpoint_tb \
   -f sources.f -o pcie_endpoint_sim &&
./obj_dir/pcie_endpoint_sim ||
{
   echo "simulation run failed"
   exit 1
}
